// ==== src/rvPkg.sv ====
package rvPkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        RETURN_B, // operandB passed through for lui
        NONE
    } aluOp_t;

    typedef enum logic [1:0] {
        ALU,
        LOAD,
        LINK, // pc + 4
        WORD  // alu result sign extended from bit 31
    } wbSel_t;

    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP32    = 7'b0111011;
    localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;

    typedef struct packed {
        logic [63:0] pc;
        logic [63:0] operandA;
        logic [63:0] operandB;
        logic [63:0] imm;
        logic [63:0] rs1;          // raw rs1 as the jalr target base
        aluOp_t      aluOp;
        wbSel_t      wbSel;
        logic        writeRd;
        logic [4:0]  rdAddr;
        logic        jump;
        logic        jumpReg;
        logic        branchTaken;
        logic        rs1To32;      // word right shifts see low half only
        logic [7:0]  memWriteMask;
        logic        memRead;
        logic        loadSigned;
        logic [3:0]  loadBytes;
    } decodedOp_t;

endpackage

// ==== src/rvDecoder.sv ====
module rvDecoder (
    input  logic [31:0]       inst,
    input  logic [63:0]       pc,
    input  logic [63:0]       rs1Data,
    input  logic [63:0]       rs2Data,
    output rvPkg::decodedOp_t op
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] immI;
    logic [63:0] immS;
    logic [63:0] immB;
    logic [63:0] immU;
    logic [63:0] immJ;
    logic [63:0] immSel;
    logic        selPc;
    logic        selImm;
    logic        taken;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // branch condition on the raw register values
    always_comb begin
        case (funct3)
            3'b000:  taken = rs1Data == rs2Data;
            3'b001:  taken = rs1Data != rs2Data;
            3'b100:  taken = $signed(rs1Data) < $signed(rs2Data);
            3'b101:  taken = $signed(rs1Data) >= $signed(rs2Data);
            3'b110:  taken = rs1Data < rs2Data;
            3'b111:  taken = rs1Data >= rs2Data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        op = '0;
        op.pc = pc;
        op.rs1 = rs1Data;
        op.rdAddr = inst[11:7];
        op.aluOp = rvPkg::NONE;
        op.wbSel = rvPkg::ALU;
        selPc = 1'b0;
        selImm = 1'b1;
        immSel = immI;
        case (opcode)
            rvPkg::OPC_OP: begin
                selImm = 1'b0;
                op.writeRd = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: op.aluOp = rvPkg::ADD;
                    10'b0100000_000: op.aluOp = rvPkg::SUB;
                    10'b0000000_001: op.aluOp = rvPkg::SLL;
                    10'b0000000_010: op.aluOp = rvPkg::SLT;
                    10'b0000000_011: op.aluOp = rvPkg::SLTU;
                    10'b0000000_100: op.aluOp = rvPkg::XOR;
                    10'b0000000_101: op.aluOp = rvPkg::SRL;
                    10'b0100000_101: op.aluOp = rvPkg::SRA;
                    10'b0000000_110: op.aluOp = rvPkg::OR;
                    10'b0000000_111: op.aluOp = rvPkg::AND;
                    default:         op.writeRd = 1'b0;
                endcase
            end
            rvPkg::OPC_OPIMM: begin
                op.writeRd = 1'b1;
                case (funct3)
                    3'b000: op.aluOp = rvPkg::ADD;
                    3'b010: op.aluOp = rvPkg::SLT;
                    3'b011: op.aluOp = rvPkg::SLTU;
                    3'b100: op.aluOp = rvPkg::XOR;
                    3'b110: op.aluOp = rvPkg::OR;
                    3'b111: op.aluOp = rvPkg::AND;
                    3'b001: op.aluOp = rvPkg::SLL;
                    default: begin
                        if (funct7[6:1] == 6'h00) begin
                            op.aluOp = rvPkg::SRL;
                        end else if (funct7[6:1] == 6'h10) begin
                            op.aluOp = rvPkg::SRA; // shamt[5] of srai sits in funct7[0]
                        end else begin
                            op.writeRd = 1'b0;
                        end
                    end
                endcase
            end
            rvPkg::OPC_OP32: begin
                selImm = 1'b0;
                op.writeRd = 1'b1;
                op.wbSel = rvPkg::WORD;
                case ({funct7, funct3})
                    10'b0000000_000: op.aluOp = rvPkg::ADD;
                    10'b0100000_000: op.aluOp = rvPkg::SUB;
                    10'b0000000_001: op.aluOp = rvPkg::SLL;
                    10'b0000000_101: begin
                        op.aluOp = rvPkg::SRL;
                        op.rs1To32 = 1'b1;
                    end
                    10'b0100000_101: begin
                        op.aluOp = rvPkg::SRA;
                        op.rs1To32 = 1'b1;
                    end
                    default:         op.writeRd = 1'b0;
                endcase
            end
            rvPkg::OPC_OPIMM32: begin
                op.writeRd = 1'b1;
                op.wbSel = rvPkg::WORD;
                case ({funct7, funct3})
                    10'b0000000_001: op.aluOp = rvPkg::SLL;
                    10'b0000000_101: begin
                        op.aluOp = rvPkg::SRL;
                        op.rs1To32 = 1'b1;
                    end
                    10'b0100000_101: begin
                        op.aluOp = rvPkg::SRA;
                        op.rs1To32 = 1'b1;
                    end
                    default: begin
                        if (funct3 == 3'b000) begin
                            op.aluOp = rvPkg::ADD; // funct7 holds addiw immediate bits
                        end else begin
                            op.writeRd = 1'b0;
                        end
                    end
                endcase
            end
            rvPkg::OPC_LUI: begin
                immSel = immU;
                op.writeRd = 1'b1;
                op.aluOp = rvPkg::RETURN_B;
            end
            rvPkg::OPC_AUIPC: begin
                immSel = immU;
                selPc = 1'b1;
                op.writeRd = 1'b1;
                op.aluOp = rvPkg::ADD;
            end
            rvPkg::OPC_JAL: begin
                immSel = immJ;
                selPc = 1'b1;
                op.writeRd = 1'b1;
                op.wbSel = rvPkg::LINK;
                op.aluOp = rvPkg::ADD;
                op.jump = 1'b1;
            end
            rvPkg::OPC_JALR: begin
                op.writeRd = 1'b1;
                op.wbSel = rvPkg::LINK;
                op.aluOp = rvPkg::ADD;
                op.jump = 1'b1;
                op.jumpReg = 1'b1;
            end
            rvPkg::OPC_BRANCH: begin
                immSel = immB;
                selPc = 1'b1;
                op.aluOp = rvPkg::ADD;
                op.branchTaken = taken;
            end
            rvPkg::OPC_LOAD: begin
                op.wbSel = rvPkg::LOAD;
                if (funct3 != 3'b111) begin
                    op.aluOp = rvPkg::ADD; // address is rs1 + imm
                    op.writeRd = 1'b1;
                    op.memRead = 1'b1;
                    op.loadSigned = ~funct3[2];
                    op.loadBytes = 4'h1 << funct3[1:0];
                end
            end
            rvPkg::OPC_STORE: begin
                immSel = immS;
                if (funct3[2] == 1'b0) begin
                    op.aluOp = rvPkg::ADD;
                    op.memWriteMask = 8'hFF >> (4'd8 - (4'd1 << funct3[1:0]));
                end
            end
            default: ; // unknown opcode stays a no-op
        endcase
        op.imm = immSel;
        op.operandA = selPc ? pc : rs1Data;
        op.operandB = selImm ? immSel : rs2Data;
    end

endmodule

// ==== src/opQueue.sv ====
module opQueue #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic              pop,
    input  rvPkg::decodedOp_t din,
    output rvPkg::decodedOp_t head,
    output logic              empty,
    output logic              full
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    rvPkg::decodedOp_t mem [DEPTH];
    logic [PW-1:0]     wrPtr;
    logic [PW-1:0]     rdPtr;
    logic [CW-1:0]     count;
    logic              wrEn;
    logic              rdEn;

    assign wrEn = push && !full;
    assign rdEn = pop && !empty;
    assign empty = count == '0;
    assign full = count == CW'(DEPTH);
    assign head = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == PW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1; // wrap for any depth
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == PW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (wrEn && !rdEn) begin
                count <= count + 1'b1;
            end else if (rdEn && !wrEn) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== src/aluExec.sv ====
module aluExec (
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,
    input  logic              empty,
    input  rvPkg::decodedOp_t head,
    output logic              pop,
    output logic              resultValid,
    output logic              rdWrite,
    output logic [4:0]        rdAddr,
    output logic [63:0]       rdValue,
    output logic [63:0]       nextPc,
    output logic [63:0]       memAddr,
    output logic [7:0]        memWriteMask,
    output logic              memRead,
    output logic [3:0]        loadBytes,
    output logic              loadSigned
);

    logic [63:0] opA;
    logic [63:0] opB;
    logic [63:0] sum;
    logic [63:0] srlSrc;
    logic [63:0] sraSrc;
    logic [5:0]  shamt;
    logic [63:0] result;
    logic [63:0] wbValue;
    logic [63:0] pcPlus4;
    logic [63:0] pcNext;

    assign opA = head.operandA;
    assign opB = head.operandB;
    assign sum = opA + opB;
    assign pcPlus4 = head.pc + 64'd4;
    assign shamt = (head.wbSel == rvPkg::WORD) ? {1'b0, opB[4:0]} : opB[5:0];
    assign srlSrc = head.rs1To32 ? {32'b0, opA[31:0]} : opA;
    assign sraSrc = head.rs1To32 ? {{32{opA[31]}}, opA[31:0]} : opA;
    assign pop = !empty && !hold;

    always_comb begin
        case (head.aluOp)
            rvPkg::ADD:      result = sum;
            rvPkg::SUB:      result = opA - opB;
            rvPkg::SLL:      result = opA << shamt;
            rvPkg::SLT:      result = {63'b0, $signed(opA) < $signed(opB)};
            rvPkg::SLTU:     result = {63'b0, opA < opB};
            rvPkg::XOR:      result = opA ^ opB;
            rvPkg::SRL:      result = srlSrc >> shamt;
            rvPkg::SRA:      result = $signed(sraSrc) >>> shamt;
            rvPkg::OR:       result = opA | opB;
            rvPkg::AND:      result = opA & opB;
            rvPkg::RETURN_B: result = opB;
            default:         result = '0;
        endcase
    end

    always_comb begin
        case (head.wbSel)
            rvPkg::WORD: wbValue = {{32{result[31]}}, result[31:0]};
            rvPkg::LINK: wbValue = pcPlus4;
            rvPkg::LOAD: wbValue = '0; // load data returns outside the slice
            default:     wbValue = result;
        endcase
    end

    always_comb begin
        if (head.jump && head.jumpReg) begin
            pcNext = (head.rs1 + head.imm) & ~64'd1;
        end else if (head.jump || head.branchTaken) begin
            pcNext = head.pc + head.imm;
        end else begin
            pcNext = pcPlus4;
        end
    end

    // control only pulses with resultValid
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            rdWrite <= 1'b0;
            memRead <= 1'b0;
            memWriteMask <= '0;
        end else begin
            resultValid <= pop;
            rdWrite <= pop && head.writeRd;
            memRead <= pop && head.memRead;
            memWriteMask <= pop ? head.memWriteMask : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rdAddr <= head.rdAddr;
            rdValue <= wbValue;
            nextPc <= pcNext;
            memAddr <= sum;
            loadBytes <= head.loadBytes;
            loadSigned <= head.loadSigned;
        end
    end

endmodule

// ==== src/rvExecCore.sv ====
module rvExecCore #(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instValid,
    input  logic [31:0] inst,
    input  logic [63:0] pc,
    input  logic [63:0] rs1Data,
    input  logic [63:0] rs2Data,
    input  logic        holdExec,
    output logic        resultValid,
    output logic        rdWrite,
    output logic [4:0]  rdAddr,
    output logic [63:0] rdValue,
    output logic [63:0] nextPc,
    output logic [63:0] memAddr,
    output logic [7:0]  memWriteMask,
    output logic        memRead,
    output logic [3:0]  loadBytes,
    output logic        loadSigned,
    output logic        queueFull
);

    rvPkg::decodedOp_t decOp;
    rvPkg::decodedOp_t headOp;
    logic              queueEmpty;
    logic              popOp;

    rvDecoder u_decoder (
        .inst    (inst),
        .pc      (pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .op      (decOp)
    );

    opQueue #(
        .DEPTH (DEPTH)
    ) u_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (instValid),
        .pop   (popOp),
        .din   (decOp),
        .head  (headOp),
        .empty (queueEmpty),
        .full  (queueFull)
    );

    aluExec u_exec (
        .clk          (clk),
        .rst          (rst),
        .hold         (holdExec),
        .empty        (queueEmpty),
        .head         (headOp),
        .pop          (popOp),
        .resultValid  (resultValid),
        .rdWrite      (rdWrite),
        .rdAddr       (rdAddr),
        .rdValue      (rdValue),
        .nextPc       (nextPc),
        .memAddr      (memAddr),
        .memWriteMask (memWriteMask),
        .memRead      (memRead),
        .loadBytes    (loadBytes),
        .loadSigned   (loadSigned)
    );

endmodule

// ==== test/rvExecCore_asserts.sv ====
module rvExecCore_asserts (
    input logic       clk,
    input logic       rst,
    input logic       instValid,
    input logic       holdExec,
    input logic       queueFull,
    input logic       resultValid,
    input logic       memRead,
    input logic [7:0] memWriteMask
);

    timeunit 1ns;
    timeprecision 1ps;

    pushWhileFull: assert property (@(posedge clk) disable iff (rst)
        !(instValid && queueFull))
        else $error("instValid pulsed while queueFull was high");

    // a held edge pops nothing
    resultAfterHold: assert property (@(posedge clk) disable iff (rst)
        holdExec |=> !resultValid)
        else $error("resultValid high after an edge with holdExec high");

    readAndWrite: assert property (@(posedge clk) disable iff (rst)
        !(memRead && memWriteMask != 8'h00))
        else $error("memRead and memWriteMask active together");

endmodule

bind rvExecCore rvExecCore_asserts u_asserts (.*);

// ==== test/rvExecCore_tb.sv ====
module rvExecCore_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSTS = 2 * 21 + 4 * 9 + 18 + 6 + 11 + 4;

    logic        clk;
    logic        rst;
    logic        instValid;
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] rs1Data;
    logic [63:0] rs2Data;
    logic        holdExec;
    logic        resultValid;
    logic        rdWrite;
    logic [4:0]  rdAddr;
    logic [63:0] rdValue;
    logic [63:0] nextPc;
    logic [63:0] memAddr;
    logic [7:0]  memWriteMask;
    logic        memRead;
    logic [3:0]  loadBytes;
    logic        loadSigned;
    logic        queueFull;

    int seed = 62;

    // stimulus waiting for its result in issue order
    logic [31:0] instQ [$];
    logic [63:0] pcQ [$];
    logic [63:0] aQ [$];
    logic [63:0] bQ [$];

    logic        expWrite;
    logic [4:0]  expRd;
    logic [63:0] expValue;
    logic [63:0] expNext;
    logic [63:0] expAddr;
    logic [7:0]  expMask;
    logic        expRead;
    logic [3:0]  expBytes;
    logic        expSigned;

    rvExecCore #(
        .DEPTH (4)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(NUM_INSTS * 40 + (RESET_CYCLES + 40) * 20);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [63:0] randPc();
        return rand64() & ~64'd3; // word aligned
    endfunction

    function automatic logic [63:0] sext32(input logic [63:0] x);
        return 64'($signed(x[31:0]));
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {f7, 5'd12, 5'd11, f3, 5'($random(seed)), opc};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm, 5'd11, f3, 5'($random(seed)), opc};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd12, 5'd11, f3, imm[4:0], rvPkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd12, 5'd11, f3, imm[4:1], imm[11], rvPkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, 5'($random(seed)), opc};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'($random(seed)), rvPkg::OPC_JAL};
    endfunction

    // integer ALU of the ISA where word forms shift only the low half
    function automatic logic [63:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [63:0] x, input logic [63:0] y,
                                           input logic word);
        logic [5:0] sh;
        sh = word ? {1'b0, y[4:0]} : y[5:0];
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << sh;
            3'd2: return 64'($signed(x) < $signed(y));
            3'd3: return 64'(x < y);
            3'd4: return x ^ y;
            3'd6: return x | y;
            3'd7: return x & y;
            default: begin
                if (word) x = alt ? sext32(x) : {32'h0, x[31:0]};
                if (alt) return $signed(x) >>> sh;
                return x >> sh;
            end
        endcase
    endfunction

    task automatic computeExpected(input logic [31:0] in, input logic [63:0] p,
                                   input logic [63:0] a, input logic [63:0] b);
        logic [63:0] immI;
        logic [63:0] immS;
        logic [63:0] immB;
        logic [63:0] immU;
        logic [63:0] immJ;
        logic [2:0]  f3;
        logic        alt;
        logic        taken;
        f3 = in[14:12];
        alt = in[30];
        immI = 64'($signed(in[31:20]));
        immS = 64'($signed({in[31:25], in[11:7]}));
        immB = 64'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
        immU = 64'($signed({in[31:12], 12'h000}));
        immJ = 64'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
        expWrite = 1'b0;
        expRd = in[11:7];
        expValue = '0;
        expNext = p + 64'd4;
        expAddr = '0;
        expMask = '0;
        expRead = 1'b0;
        expBytes = '0;
        expSigned = 1'b0;
        case (in[6:0])
            rvPkg::OPC_OP: begin
                expWrite = 1'b1;
                expValue = aluRef(f3, alt, a, b, 1'b0);
            end
            rvPkg::OPC_OPIMM: begin
                expWrite = 1'b1;
                expValue = aluRef(f3, alt && f3 == 3'd5, a, immI, 1'b0); // alt only for srai
            end
            rvPkg::OPC_OP32: begin
                expWrite = 1'b1;
                expValue = sext32(aluRef(f3, alt, a, b, 1'b1));
            end
            rvPkg::OPC_OPIMM32: begin
                expWrite = 1'b1;
                expValue = sext32(aluRef(f3, alt && f3 == 3'd5, a, immI, 1'b1));
            end
            rvPkg::OPC_LUI: begin
                expWrite = 1'b1;
                expValue = immU;
            end
            rvPkg::OPC_AUIPC: begin
                expWrite = 1'b1;
                expValue = p + immU;
            end
            rvPkg::OPC_JAL: begin
                expWrite = 1'b1;
                expValue = p + 64'd4;
                expNext = p + immJ;
            end
            rvPkg::OPC_JALR: begin
                expWrite = 1'b1;
                expValue = p + 64'd4;
                expNext = (a + immI) & ~64'd1;
            end
            rvPkg::OPC_BRANCH: begin
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) expNext = p + immB;
            end
            rvPkg::OPC_LOAD: begin
                expWrite = 1'b1;
                expRead = 1'b1;
                expAddr = a + immI;
                expBytes = 4'(1 << f3[1:0]);
                expSigned = !f3[2];
            end
            rvPkg::OPC_STORE: begin
                expAddr = a + immS;
                expMask = 8'((16'd1 << (4'd1 << f3[1:0])) - 16'd1); // one bit per byte
            end
            default: ;
        endcase
    endtask

    // drives one push on the falling edge and returns a cycle later
    task automatic issue(input logic [31:0] in, input logic [63:0] p,
                         input logic [63:0] a, input logic [63:0] b);
        inst = in;
        pc = p;
        rs1Data = a;
        rs2Data = b;
        instValid = 1'b1;
        instQ.push_back(in);
        pcQ.push_back(p);
        aQ.push_back(a);
        bQ.push_back(b);
        @(negedge clk);
        instValid = 1'b0;
        checkValue("resultValid", 64'(resultValid), 64'd0);
    endtask

    task automatic expectResult();
        computeExpected(instQ.pop_front(), pcQ.pop_front(), aQ.pop_front(), bQ.pop_front());
        checkValue("resultValid", 64'(resultValid), 64'd1);
        checkValue("rdWrite", 64'(rdWrite), 64'(expWrite));
        if (expWrite) begin
            checkValue("rdAddr", 64'(rdAddr), 64'(expRd));
            checkValue("rdValue", rdValue, expValue);
        end
        checkValue("nextPc", nextPc, expNext);
        checkValue("memRead", 64'(memRead), 64'(expRead));
        checkValue("memWriteMask", 64'(memWriteMask), 64'(expMask));
        if (expRead || expMask != 8'h00) begin
            checkValue("memAddr", memAddr, expAddr);
        end
        if (expRead) begin
            checkValue("loadBytes", 64'(loadBytes), 64'(expBytes));
            checkValue("loadSigned", 64'(loadSigned), 64'(expSigned));
        end
    endtask

    task automatic runInst(input logic [31:0] in, input logic [63:0] p,
                           input logic [63:0] a, input logic [63:0] b);
        issue(in, p, a, b);
        @(negedge clk); // second edge registers the result
        expectResult();
    endtask

    task automatic testReset();
        checkValue("resultValid", 64'(resultValid), 64'd0);
        checkValue("rdWrite", 64'(rdWrite), 64'd0);
        checkValue("memRead", 64'(memRead), 64'd0);
        checkValue("queueFull", 64'(queueFull), 64'd0);
        checkValue("memWriteMask", 64'(memWriteMask), 64'd0);
    endtask

    task automatic testInteger();
        logic [31:0] ops [$];
        logic [5:0]  sh;
        for (int pass = 0; pass < 2; pass++) begin
            sh = 6'($random(seed));
            ops = {rType(7'h00, 3'd0, rvPkg::OPC_OP), rType(7'h20, 3'd0, rvPkg::OPC_OP),
                   rType(7'h00, 3'd1, rvPkg::OPC_OP), rType(7'h00, 3'd2, rvPkg::OPC_OP),
                   rType(7'h00, 3'd3, rvPkg::OPC_OP), rType(7'h00, 3'd4, rvPkg::OPC_OP),
                   rType(7'h00, 3'd5, rvPkg::OPC_OP), rType(7'h20, 3'd5, rvPkg::OPC_OP),
                   rType(7'h00, 3'd6, rvPkg::OPC_OP), rType(7'h00, 3'd7, rvPkg::OPC_OP),
                   iType(12'($random(seed)), 3'd0, rvPkg::OPC_OPIMM),
                   iType(12'($random(seed)), 3'd2, rvPkg::OPC_OPIMM),
                   iType(12'($random(seed)), 3'd3, rvPkg::OPC_OPIMM),
                   iType(12'($random(seed)), 3'd4, rvPkg::OPC_OPIMM),
                   iType(12'($random(seed)), 3'd6, rvPkg::OPC_OPIMM),
                   iType(12'($random(seed)), 3'd7, rvPkg::OPC_OPIMM),
                   iType({6'h00, sh}, 3'd1, rvPkg::OPC_OPIMM),
                   iType({6'h00, sh}, 3'd5, rvPkg::OPC_OPIMM),
                   iType({6'h10, sh}, 3'd5, rvPkg::OPC_OPIMM),
                   uType(20'($random(seed)), rvPkg::OPC_LUI),
                   uType(20'($random(seed)), rvPkg::OPC_AUIPC)};
            foreach (ops[i]) runInst(ops[i], randPc(), rand64(), rand64());
        end
    endtask

    // low halves and shift amounts give result bit 31 both set and clear
    task automatic testWord();
        logic [31:0] lows [4];
        logic [4:0]  shs [4];
        logic [31:0] ops [$];
        lows = '{32'h8765_4321, 32'h8765_4321, 32'h1234_5678, 32'h4321_8765};
        shs = '{5'd0, 5'd5, 5'd4, 5'd1};
        for (int pass = 0; pass < 4; pass++) begin
            ops = {rType(7'h00, 3'd0, rvPkg::OPC_OP32), rType(7'h20, 3'd0, rvPkg::OPC_OP32),
                   rType(7'h00, 3'd1, rvPkg::OPC_OP32), rType(7'h00, 3'd5, rvPkg::OPC_OP32),
                   rType(7'h20, 3'd5, rvPkg::OPC_OP32),
                   iType({7'h00, shs[pass]}, 3'd0, rvPkg::OPC_OPIMM32),
                   iType({7'h00, shs[pass]}, 3'd1, rvPkg::OPC_OPIMM32),
                   iType({7'h00, shs[pass]}, 3'd5, rvPkg::OPC_OPIMM32),
                   iType({7'h20, shs[pass]}, 3'd5, rvPkg::OPC_OPIMM32)};
            foreach (ops[i]) begin
                runInst(ops[i], randPc(), {32'($random(seed)), lows[pass]},
                        {32'($random(seed)), 26'd0, 1'(pass), shs[pass]}); // bit 5 is ignored
            end
        end
    endtask

    task automatic testControl();
        logic [63:0] x;
        logic [63:0] lhs [3];
        logic [63:0] rhs [3];
        logic [2:0]  conds [6];
        x = rand64();
        lhs = '{x, 64'hFFFF_FFFF_FFFF_FF00, 64'h0000_0000_0000_0100};
        rhs = '{x, 64'h0000_0000_0000_0100, 64'hFFFF_FFFF_FFFF_FF00};
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        foreach (conds[c]) begin
            for (int k = 0; k < 3; k++) begin
                runInst(bType({12'($random(seed)), 1'b0}, conds[c]), randPc(), lhs[k], rhs[k]);
            end
        end
        for (int k = 0; k < 3; k++) begin
            runInst(jType({20'($random(seed)), 1'b0}), randPc(), rand64(), rand64());
            runInst(iType(12'($random(seed)) & 12'hFFE, 3'd0, rvPkg::OPC_JALR), randPc(),
                    rand64() | 64'd1, rand64()); // odd target so bit 0 gets cleared
        end
    endtask

    task automatic testMemory();
        for (int f = 0; f < 7; f++) begin
            runInst(iType(12'($random(seed)), 3'(f), rvPkg::OPC_LOAD), randPc(), rand64(),
                    rand64());
        end
        for (int f = 0; f < 4; f++) begin
            runInst(sType(12'($random(seed)), 3'(f)), randPc(), rand64(), rand64());
        end
    endtask

    task automatic testBackPressure();
        holdExec = 1'b1;
        for (int k = 0; k < 4; k++) begin
            issue(rType(7'h00, 3'(k * 2), rvPkg::OPC_OP), randPc(), rand64(), rand64());
        end
        checkValue("queueFull", 64'(queueFull), 64'd1);
        holdExec = 1'b0;
        repeat (4) begin
            @(negedge clk);
            expectResult();
        end
        @(negedge clk);
        checkValue("resultValid", 64'(resultValid), 64'd0);
        checkValue("queueFull", 64'(queueFull), 64'd0);
    endtask

    initial begin
        rst = 1'b1;
        instValid = 1'b0;
        inst = '0;
        pc = '0;
        rs1Data = '0;
        rs2Data = '0;
        holdExec = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testReset();
        testInteger();
        testWord();
        testControl();
        testMemory();
        testBackPressure();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
src/rvPkg.sv
src/rvDecoder.sv
src/opQueue.sv
src/aluExec.sv
src/rvExecCore.sv
test/rvExecCore_asserts.sv
test/rvExecCore_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = rvExecCore_tb
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
